/* verilog/phone_ui_settings.svh */
`ifndef PHONE_UI_SETTINGS_SVH
`define PHONE_UI_SETTINGS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// text engine address and length
`define UI_TEXT_ADDR_W 11

// dialed number from the switches
`define UI_DIAL_W 8

// headphone volume
`define UI_VOL_W 5

//////////////////////////////////////////////////
// volume range
//////////////////////////////////////////////////

`define UI_VOL_DEFAULT 16 // mid scale out of reset
`define UI_VOL_MAX 31     // full scale, bottom is 0

//////////////////////////////////////////////////
// ring timer
//////////////////////////////////////////////////

// clocks per tick, kept tiny so a ring fits in a short sim
`define UI_RING_TICK_DIV 4

// ticks before an unanswered call is resolved
`define UI_RING_COUNT 30

`endif

/* verilog/phone_ui_pkg.sv */
package phone_ui_pkg;

	//////////////////////////////////////////////////
	// call states
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		idle       = 3'd0, // no call
		incoming   = 3'd1, // we are being called
		outgoing   = 3'd2, // we are calling out
		busy       = 3'd3, // call in progress
		initialize = 3'd5  // waiting for enter after power up
	} call_state_e;

	//////////////////////////////////////////////////
	// menu items, codes match the text engine tables
	//////////////////////////////////////////////////
	typedef enum logic [5:0] {
		call_number  = 6'd0,  // main menu
		volume       = 6'd1,
		voicemail    = 6'd2,  // hidden without a storage card
		get_num      = 6'd3,
		dialing      = 6'd7,  // switches hold the number
		change_vol   = 6'd8,
		toggle_v     = 6'd9,
		def_incoming = 6'd32, // incoming call menu
		accept       = 6'd33,
		reject       = 6'd34,
		send_to_v    = 6'd35,
		def_outgoing = 6'd36, // outgoing call menu
		end_call     = 6'd37,
		def_busy     = 6'd38, // call in progress menu
		end_call_b   = 6'd39,
		set_volume   = 6'd40,
		def_welcome  = 6'd50, // idle default screen
		def_init     = 6'd51
	} menu_item_e;

	// commands to the application layer
	typedef enum logic [2:0] {
		cmd_none        = 3'd0,
		make_call       = 3'd1,
		stop_call       = 3'd2,
		accept_call     = 3'd3,
		go_to_voicemail = 3'd4
	} ui_cmd_e;

	// event codes back from the application layer
	typedef enum logic [2:0] {
		evt_none      = 3'd0,
		connected     = 3'd1, // call went through
		sent_to_v     = 3'd2, // caller diverted to voicemail
		failed        = 3'd4, // dropped or never connected
		incoming_call = 3'd5,
		call_ended    = 3'd6
	} app_evt_e;

endpackage

/* verilog/call_control_fsm.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module call_control_fsm import phone_ui_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  up,
	input  logic                  down,
	input  logic                  left,
	input  logic                  right,
	input  logic                  enter,
	input  logic [`UI_DIAL_W-1:0] switches,
	input  logic                  cf_present,
	input  app_evt_e              app_event,
	input  logic                  vm_enable,
	input  logic [`UI_VOL_W-1:0]  volume,
	input  logic                  ring_expired,
	output call_state_e           state,
	output menu_item_e            menu_item,
	output ui_cmd_e               command,
	output logic [`UI_DIAL_W-1:0] dial_address,
	output logic                  vol_up,
	output logic                  vol_down,
	output logic                  vm_toggle,
	output logic                  ring_start,
	output logic                  ring_stop
);

	localparam logic [`UI_VOL_W-1:0] vol_max = `UI_VOL_MAX;

	logic sel;        // right and enter both select
	logic vm_ok;      // voicemail usable right now
	logic vol_inc_ok;
	logic vol_dec_ok;
	logic in_main;    // sitting on a main menu entry

	assign sel = right | enter;
	assign vm_ok = vm_enable & cf_present;
	assign vol_inc_ok = volume < vol_max;
	assign vol_dec_ok = volume != '0;
	assign in_main = menu_item inside {call_number, phone_ui_pkg::volume, voicemail, get_num};
	assign ring_stop = state != incoming; // timer only runs while ringing

	always_ff @(posedge clk) begin
		vol_up <= 1'b0; // strobes live for one cycle
		vol_down <= 1'b0;
		vm_toggle <= 1'b0;
		ring_start <= 1'b0;
		if (reset) begin
			state <= initialize;
			menu_item <= def_init;
			command <= cmd_none;
			dial_address <= '0;
		end else begin
			case (state)
				//////////////////////////////////////////////////
				// power up, wait for enter
				//////////////////////////////////////////////////
				initialize: begin
					if (enter) begin
						state <= idle;
						menu_item <= def_welcome;
					end
				end

				//////////////////////////////////////////////////
				// idle, main menu tree
				//////////////////////////////////////////////////
				idle: begin
					if (app_event == incoming_call) begin // ringing beats buttons
						state <= incoming;
						menu_item <= def_incoming;
						ring_start <= 1'b1;
					end else if (up) begin
						case (menu_item)
							call_number: menu_item <= get_num; // wrap to bottom
							phone_ui_pkg::volume: menu_item <= call_number;
							voicemail: menu_item <= phone_ui_pkg::volume;
							get_num: begin
								if (cf_present)
									menu_item <= voicemail;
								else
									menu_item <= phone_ui_pkg::volume; // no card, skip voicemail
							end
							change_vol: vol_up <= vol_inc_ok;
							default: ;
						endcase
					end else if (down) begin
						case (menu_item)
							call_number: menu_item <= phone_ui_pkg::volume;
							phone_ui_pkg::volume: begin
								if (cf_present)
									menu_item <= voicemail;
								else
									menu_item <= get_num;
							end
							voicemail: menu_item <= get_num;
							get_num: menu_item <= call_number; // wrap to top
							change_vol: vol_down <= vol_dec_ok;
							default: ;
						endcase
					end else if (sel) begin
						case (menu_item)
							def_welcome: menu_item <= call_number;
							call_number: menu_item <= dialing;
							phone_ui_pkg::volume: menu_item <= change_vol;
							voicemail: menu_item <= toggle_v;
							dialing: begin
								dial_address <= switches; // number latched at dial time
								command <= make_call;
								state <= outgoing;
								menu_item <= def_outgoing;
							end
							toggle_v: vm_toggle <= 1'b1;
							default: ;
						endcase
					end else if (left) begin
						if (in_main)
							menu_item <= def_welcome;
						else if (menu_item == dialing)
							menu_item <= call_number;
						else if (menu_item == change_vol)
							menu_item <= phone_ui_pkg::volume;
						else if (menu_item == toggle_v)
							menu_item <= voicemail;
					end
				end

				//////////////////////////////////////////////////
				// incoming, ringing
				//////////////////////////////////////////////////
				incoming: begin
					if (app_event == connected) begin
						state <= busy;
						menu_item <= def_busy;
					end else if (app_event == call_ended || app_event == sent_to_v) begin
						state <= idle;
						menu_item <= def_welcome;
					end else if (ring_expired) begin
						if (vm_ok)
							command <= go_to_voicemail; // nobody answered
						else
							command <= stop_call;
					end else if (up) begin
						case (menu_item)
							def_incoming: begin
								if (vm_ok)
									menu_item <= send_to_v;
								else
									menu_item <= reject;
							end
							accept: menu_item <= def_incoming;
							reject: menu_item <= accept;
							send_to_v: menu_item <= reject;
							default: ;
						endcase
					end else if (down) begin
						case (menu_item)
							def_incoming: menu_item <= accept;
							accept: menu_item <= reject;
							reject: begin
								if (vm_ok)
									menu_item <= send_to_v;
								else
									menu_item <= def_incoming;
							end
							send_to_v: menu_item <= def_incoming;
							default: ;
						endcase
					end else if (sel) begin
						case (menu_item)
							def_incoming: command <= accept_call; // select on banner answers
							accept: command <= accept_call;
							reject: command <= stop_call;
							send_to_v: command <= go_to_voicemail;
							default: ;
						endcase
					end
				end

				//////////////////////////////////////////////////
				// outgoing, waiting on far end
				//////////////////////////////////////////////////
				outgoing: begin
					if (app_event == connected) begin
						state <= busy;
						menu_item <= def_busy;
					end else if (app_event == failed || app_event == call_ended) begin
						state <= idle;
						menu_item <= def_welcome;
					end else if (up || down) begin
						if (menu_item == def_outgoing) // two entries, just flip
							menu_item <= end_call;
						else
							menu_item <= def_outgoing;
					end else if (sel && menu_item == end_call) begin
						command <= stop_call;
					end
				end

				//////////////////////////////////////////////////
				// busy, call in progress
				//////////////////////////////////////////////////
				busy: begin
					if (app_event == call_ended) begin
						state <= idle;
						menu_item <= def_welcome;
					end else if (up) begin
						case (menu_item)
							def_busy: menu_item <= set_volume;
							end_call_b: menu_item <= def_busy;
							set_volume: menu_item <= end_call_b;
							change_vol: vol_up <= vol_inc_ok;
							default: ;
						endcase
					end else if (down) begin
						case (menu_item)
							def_busy: menu_item <= end_call_b;
							end_call_b: menu_item <= set_volume;
							set_volume: menu_item <= def_busy;
							change_vol: vol_down <= vol_dec_ok;
							default: ;
						endcase
					end else if (sel) begin
						case (menu_item)
							end_call_b: command <= stop_call;
							set_volume: menu_item <= change_vol;
							default: ;
						endcase
					end else if (left && menu_item == change_vol) begin
						menu_item <= set_volume;
					end
				end

				default: begin // unused encodings fall back to idle
					state <= idle;
					menu_item <= def_welcome;
				end
			endcase
		end
	end

endmodule

/* verilog/menu_text_rom.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module menu_text_rom import phone_ui_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  menu_item_e                 menu_item,
	input  logic                       vm_enable,
	output logic [`UI_TEXT_ADDR_W-1:0] text_addr,
	output logic [`UI_TEXT_ADDR_W-1:0] text_len,
	output logic                       text_start
);

	localparam int aw = `UI_TEXT_ADDR_W;

	// packs one table row, address in the upper half
	function automatic logic [2*aw-1:0] text_entry(input int addr, input int len);
		text_entry = {aw'(addr), aw'(len)};
	endfunction

	logic [5:0]      prev_item; // item seen last cycle
	logic            item_changed;
	logic [2*aw-1:0] lu;        // looked up address and length

	assign item_changed = prev_item != menu_item;

	//////////////////////////////////////////////////
	// text table, start address and length
	//////////////////////////////////////////////////
	always_comb begin
		case (menu_item)
			def_init: lu = text_entry(0, 45);      // press enter to start
			def_welcome: lu = text_entry(72, 7);
			call_number: lu = text_entry(80, 11);
			volume: lu = text_entry(92, 20);
			voicemail: lu = text_entry(128, 9);
			get_num: lu = text_entry(468, 21);
			toggle_v: begin
				if (vm_enable)
					lu = text_entry(138, 18); // offer to turn it off
				else
					lu = text_entry(157, 17); // offer to turn it on
			end
			def_incoming: lu = text_entry(361, 13);
			accept: lu = text_entry(375, 20);
			reject: lu = text_entry(396, 20);
			send_to_v: lu = text_entry(417, 17);
			def_outgoing: lu = text_entry(435, 7);
			end_call: lu = text_entry(443, 8);     // same string in both menus
			end_call_b: lu = text_entry(443, 8);
			def_busy: lu = text_entry(490, 12);
			default: lu = '0;                      // no text for this item
		endcase
	end

	// address and length only move on a new item
	always_ff @(posedge clk) begin
		if (item_changed) begin
			text_addr <= lu[2*aw-1:aw];
			text_len <= lu[aw-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prev_item <= '1; // never a valid item, forces a first load
			text_start <= 1'b0;
		end else begin
			prev_item <= menu_item;
			text_start <= item_changed; // one pulse per change
		end
	end

endmodule

/* verilog/ring_timer.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module ring_timer #(
	parameter int tick_div   = `UI_RING_TICK_DIV,
	parameter int ring_count = `UI_RING_COUNT
) (
	input  logic clk,
	input  logic reset,
	input  logic ring_start,
	input  logic ring_stop,
	output logic ring_expired
);

	localparam int presc_w = (tick_div > 1) ? $clog2(tick_div) : 1;
	localparam int tick_w = (ring_count > 1) ? $clog2(ring_count) : 1;
	localparam logic [presc_w-1:0] presc_top = presc_w'(tick_div - 1);
	localparam logic [tick_w-1:0] tick_top = tick_w'(ring_count - 1);

	logic [presc_w-1:0] presc;      // cycles within the current tick
	logic [tick_w-1:0]  ticks_left; // whole ticks still to go
	logic               running;
	logic               tick_done;

	assign tick_done = presc == presc_top;
	// last cycle of the last tick
	assign ring_expired = running & tick_done & (ticks_left == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			presc <= '0;
			ticks_left <= '0;
		end else if (ring_start) begin // restart wins over stop
			running <= 1'b1;
			presc <= '0;
			ticks_left <= tick_top;
		end else if (ring_stop || ring_expired) begin
			running <= 1'b0; // answered, dropped or done
		end else if (running) begin
			if (tick_done) begin
				presc <= '0;
				ticks_left <= ticks_left - 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

endmodule

/* verilog/ui_config_regs.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module ui_config_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 vol_up,
	input  logic                 vol_down,
	input  logic                 vm_toggle,
	output logic [`UI_VOL_W-1:0] volume,
	output logic                 vm_enable
);

	localparam logic [`UI_VOL_W-1:0] vol_max = `UI_VOL_MAX;
	localparam logic [`UI_VOL_W-1:0] vol_default = `UI_VOL_DEFAULT;

	logic at_top;
	logic at_bottom;

	// saturate here too, the FSM guard sees volume one cycle late
	assign at_top = volume == vol_max;
	assign at_bottom = volume == '0;

	//////////////////////////////////////////////////
	// headphone volume
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			volume <= vol_default;
		end else if (vol_up && !at_top) begin
			volume <= volume + 1'b1;
		end else if (vol_down && !at_bottom) begin
			volume <= volume - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// voicemail enable
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			vm_enable <= 1'b0; // off until the user turns it on
		else if (vm_toggle)
			vm_enable <= ~vm_enable;
	end

endmodule

/* verilog/phone_ui_top.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module phone_ui_top import phone_ui_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       up,
	input  logic                       down,
	input  logic                       left,
	input  logic                       right,
	input  logic                       enter,
	input  logic [`UI_DIAL_W-1:0]      switches,
	input  logic                       cf_present,
	input  app_evt_e                   app_event,
	output call_state_e                current_state,
	output menu_item_e                 menu_item,
	output ui_cmd_e                    command,
	output logic [`UI_DIAL_W-1:0]      dial_address,
	output logic [`UI_VOL_W-1:0]       headphone_volume,
	output logic                       vm_enable,
	output logic [`UI_TEXT_ADDR_W-1:0] text_addr,
	output logic [`UI_TEXT_ADDR_W-1:0] text_len,
	output logic                       text_start
);

	logic vol_up;       // config strobes
	logic vol_down;
	logic vm_toggle;
	logic ring_start;   // ring timer handshake
	logic ring_stop;
	logic ring_expired;

	call_control_fsm fsm0 (
		.clk(clk),
		.reset(reset),
		.up(up),
		.down(down),
		.left(left),
		.right(right),
		.enter(enter),
		.switches(switches),
		.cf_present(cf_present),
		.app_event(app_event),
		.vm_enable(vm_enable),
		.volume(headphone_volume),
		.ring_expired(ring_expired),
		.state(current_state),
		.menu_item(menu_item),
		.command(command),
		.dial_address(dial_address),
		.vol_up(vol_up),
		.vol_down(vol_down),
		.vm_toggle(vm_toggle),
		.ring_start(ring_start),
		.ring_stop(ring_stop)
	);

	ui_config_regs cfg0 (
		.clk(clk),
		.reset(reset),
		.vol_up(vol_up),
		.vol_down(vol_down),
		.vm_toggle(vm_toggle),
		.volume(headphone_volume),
		.vm_enable(vm_enable)
	);

	ring_timer #(
		.tick_div(`UI_RING_TICK_DIV),
		.ring_count(`UI_RING_COUNT)
	) ring0 (
		.clk(clk),
		.reset(reset),
		.ring_start(ring_start),
		.ring_stop(ring_stop),
		.ring_expired(ring_expired)
	);

	menu_text_rom text0 (
		.clk(clk),
		.reset(reset),
		.menu_item(menu_item),
		.vm_enable(vm_enable),
		.text_addr(text_addr),
		.text_len(text_len),
		.text_start(text_start)
	);

endmodule

/* testbench/phone_ui_properties.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module phone_ui_properties import phone_ui_pkg::*; (
	input logic                 clk,
	input logic                 reset,
	input menu_item_e           menu_item,
	input logic                 text_start,
	input logic [`UI_VOL_W-1:0] headphone_volume,
	input ui_cmd_e              command,
	input call_state_e          current_state
);

	localparam logic [`UI_VOL_W-1:0] vol_max = `UI_VOL_MAX;

	// a text run needs a new item, except the forced load just out of reset
	text_start_after_change: assert property (@(posedge clk) disable iff (reset)
		text_start |-> ($past(menu_item) != $past(menu_item, 2)) || $past(reset, 2))
		else $error("text_start without a menu_item change");

	// full scale holds, never wraps back to the bottom
	vol_in_range: assert property (@(posedge clk) disable iff (reset)
		$past(headphone_volume) == vol_max |-> headphone_volume >= vol_max - 1'b1)
		else $error("headphone_volume wrapped past the top of the range");

	// nothing to command before the user presses enter
	cmd_held_in_init: assert property (@(posedge clk) disable iff (reset)
		current_state == initialize |-> $stable(command))
		else $error("command changed in the initialize state");

endmodule

bind phone_ui_top phone_ui_properties props0 (
	.clk(clk),
	.reset(reset),
	.menu_item(menu_item),
	.text_start(text_start),
	.headphone_volume(headphone_volume),
	.command(command),
	.current_state(current_state)
);

/* testbench/phone_ui_tb.sv */
`timescale 1ns/1ps
`include "phone_ui_settings.svh"

module phone_ui_tb import phone_ui_pkg::*; ();

	localparam int reset_cycles = 16;
	localparam int ring_cycles = `UI_RING_TICK_DIV * `UI_RING_COUNT;

	// button sets, packed as {up, down, left, right, enter}
	localparam logic [4:0] b_none = 5'b00000;
	localparam logic [4:0] b_up = 5'b10000;
	localparam logic [4:0] b_down = 5'b01000;
	localparam logic [4:0] b_left = 5'b00100;
	localparam logic [4:0] b_right = 5'b00010;
	localparam logic [4:0] b_enter = 5'b00001;

	typedef logic [`UI_DIAL_W-1:0] dial_t;
	typedef logic [`UI_VOL_W-1:0] vol_t;
	typedef logic [`UI_TEXT_ADDR_W-1:0] text_t;

	// one table row, stimulus then expected values
	typedef struct packed {
		logic [4:0]  btn;
		app_evt_e    evt;
		dial_t       sw;
		logic        cf;
		int          reps;     // button presses in this row
		int          wait_max; // extra cycles allowed to settle
		call_state_e st;
		menu_item_e  item;
		ui_cmd_e     cmd;
		dial_t       dial;
		vol_t        vol;
		logic        vm;
		logic        start;    // text run expected on a new item
		logic        chk_text;
		text_t       addr;
		text_t       len;
	} step_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        up;
	logic        down;
	logic        left;
	logic        right;
	logic        enter;
	dial_t       switches;
	logic        cf_present;
	app_evt_e    app_event;
	call_state_e current_state;
	menu_item_e  menu_item;
	ui_cmd_e     command;
	dial_t       dial_address;
	vol_t        headphone_volume;
	logic        vm_enable;
	text_t       text_addr;
	text_t       text_len;
	logic        text_start;

	step_t steps[$];
	dial_t row_sw = '0;  // levels carried into the next rows
	logic  row_cf = 1'b0;
	int    row_reps = 1;
	int    row_wait = 0;
	int    step_idx = 0;
	int    press_total = 0;
	int    cycle_limit = 0;
	int    cycle_count = 0;

	phone_ui_top dut0 (.*);

	always #2 clk = ~clk; // 4 ns period

	//////////////////////////////////////////////////
	// table building
	//////////////////////////////////////////////////

	function automatic void set_repeat(input int reps, input int wait_cycles);
		row_reps = reps;
		row_wait = wait_cycles;
	endfunction

	// addr below 0 skips the text check
	function automatic void add_step(input logic [4:0] btn, input app_evt_e evt,
			input call_state_e st, input menu_item_e item, input ui_cmd_e cmd,
			input int dial, input int vol, input int vm, input int addr, input int len);
		step_t s;
		s.btn = btn;
		s.evt = evt;
		s.sw = row_sw;
		s.cf = row_cf;
		s.reps = row_reps;
		s.wait_max = row_wait;
		s.st = st;
		s.item = item;
		s.cmd = cmd;
		s.dial = dial_t'(dial);
		s.vol = vol_t'(vol);
		s.vm = vm[0];
		s.start = steps.size() > 0 && steps[$].item != item;
		s.chk_text = addr >= 0;
		s.addr = text_t'(addr);
		s.len = text_t'(len);
		steps.push_back(s);
		row_reps = 1; // repeat and wait apply to one row only
		row_wait = 0;
	endfunction

	//////////////////////////////////////////////////
	// drive and check
	//////////////////////////////////////////////////

	task automatic drive_step(input step_t s);
		{up, down, left, right, enter} <= s.btn;
		app_event <= s.evt;
		switches <= s.sw;
		cf_present <= s.cf;
	endtask

	task automatic release_buttons();
		{up, down, left, right, enter} <= 5'b00000;
		app_event <= evt_none; // switches and card level stay put
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: step %0d %s = 0x%h, expected 0x%h", step_idx, name, actual,
				expected);
			$display("=== FAIL ===");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic bit step_matches(input step_t s);
		return current_state == s.st && menu_item == s.item && command == s.cmd
			&& dial_address == s.dial && headphone_volume == s.vol && vm_enable == s.vm;
	endfunction

	task automatic compare_step(input step_t s);
		check_value("current_state", 32'(current_state), 32'(s.st));
		check_value("menu_item", 32'(menu_item), 32'(s.item));
		check_value("command", 32'(command), 32'(s.cmd));
		check_value("dial_address", 32'(dial_address), 32'(s.dial));
		check_value("headphone_volume", 32'(headphone_volume), 32'(s.vol));
		check_value("vm_enable", 32'(vm_enable), 32'(s.vm));
		check_value("text_start", 32'(text_start), 32'(s.start));
		if (s.chk_text) begin
			check_value("text_addr", 32'(text_addr), 32'(s.addr));
			check_value("text_len", 32'(text_len), 32'(s.len));
		end
	endtask

	// press for a cycle, release for a cycle, then look after the text/volume regs load
	task automatic apply_step(input step_t s);
		int waited;
		for (int r = 0; r < s.reps; r++) begin
			@(posedge clk);
			drive_step(s);
			@(posedge clk);
			release_buttons();
		end
		@(posedge clk);
		@(negedge clk); // outputs settled mid cycle
		waited = 0;
		while (waited < s.wait_max && !step_matches(s)) begin
			@(negedge clk);
			waited++;
		end
		compare_step(s);
	endtask

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////

	function automatic void build_table();
		// power up, then enter
		add_step(b_none, evt_none, initialize, def_init, cmd_none, 0, 16, 0, 0, 45);
		add_step(b_enter, evt_none, idle, def_welcome, cmd_none, 0, 16, 0, 72, 7);
		// main menu without a card, voicemail hidden
		add_step(b_right, evt_none, idle, call_number, cmd_none, 0, 16, 0, 80, 11);
		add_step(b_up, evt_none, idle, get_num, cmd_none, 0, 16, 0, 468, 21);
		add_step(b_down, evt_none, idle, call_number, cmd_none, 0, 16, 0, 80, 11);
		add_step(b_down, evt_none, idle, volume, cmd_none, 0, 16, 0, 92, 20);
		add_step(b_down, evt_none, idle, get_num, cmd_none, 0, 16, 0, 468, 21);
		add_step(b_up, evt_none, idle, volume, cmd_none, 0, 16, 0, 92, 20);
		add_step(b_left, evt_none, idle, def_welcome, cmd_none, 0, 16, 0, 72, 7);
		// card in, voicemail toggle, text held while the item stays
		row_cf = 1'b1;
		add_step(b_enter, evt_none, idle, call_number, cmd_none, 0, 16, 0, 80, 11);
		add_step(b_down, evt_none, idle, volume, cmd_none, 0, 16, 0, 92, 20);
		add_step(b_down, evt_none, idle, voicemail, cmd_none, 0, 16, 0, 128, 9);
		add_step(b_right, evt_none, idle, toggle_v, cmd_none, 0, 16, 0, 157, 17);
		add_step(b_enter, evt_none, idle, toggle_v, cmd_none, 0, 16, 1, 157, 17);
		add_step(b_left, evt_none, idle, voicemail, cmd_none, 0, 16, 1, 128, 9);
		add_step(b_right, evt_none, idle, toggle_v, cmd_none, 0, 16, 1, 138, 18);
		add_step(b_right, evt_none, idle, toggle_v, cmd_none, 0, 16, 0, 138, 18);
		add_step(b_left, evt_none, idle, voicemail, cmd_none, 0, 16, 0, 128, 9);
		add_step(b_right, evt_none, idle, toggle_v, cmd_none, 0, 16, 0, 157, 17);
		add_step(b_enter, evt_none, idle, toggle_v, cmd_none, 0, 16, 1, 157, 17);
		add_step(b_left, evt_none, idle, voicemail, cmd_none, 0, 16, 1, 128, 9);
		add_step(b_left, evt_none, idle, def_welcome, cmd_none, 0, 16, 1, 72, 7);
		// volume up to the top and saturate
		add_step(b_enter, evt_none, idle, call_number, cmd_none, 0, 16, 1, 80, 11);
		add_step(b_down, evt_none, idle, volume, cmd_none, 0, 16, 1, 92, 20);
		add_step(b_right, evt_none, idle, change_vol, cmd_none, 0, 16, 1, 0, 0);
		set_repeat(6, 0);
		add_step(b_up, evt_none, idle, change_vol, cmd_none, 0, 22, 1, 0, 0);
		set_repeat(20, 8);
		add_step(b_up, evt_none, idle, change_vol, cmd_none, 0, 31, 1, 0, 0);
		add_step(b_left, evt_none, idle, volume, cmd_none, 0, 31, 1, 92, 20);
		add_step(b_left, evt_none, idle, def_welcome, cmd_none, 0, 31, 1, 72, 7);
		// dial out, connect, turn down, hang up
		add_step(b_right, evt_none, idle, call_number, cmd_none, 0, 31, 1, 80, 11);
		add_step(b_right, evt_none, idle, dialing, cmd_none, 0, 31, 1, 0, 0);
		row_sw = 8'h5a;
		add_step(b_right, evt_none, outgoing, def_outgoing, make_call, 'h5a, 31, 1, 435, 7);
		row_sw = 8'h00; // number already latched
		add_step(b_none, connected, busy, def_busy, make_call, 'h5a, 31, 1, 490, 12);
		add_step(b_down, evt_none, busy, end_call_b, make_call, 'h5a, 31, 1, 443, 8);
		add_step(b_down, evt_none, busy, set_volume, make_call, 'h5a, 31, 1, 0, 0);
		add_step(b_right, evt_none, busy, change_vol, make_call, 'h5a, 31, 1, 0, 0);
		add_step(b_down, evt_none, busy, change_vol, make_call, 'h5a, 30, 1, 0, 0);
		add_step(b_left, evt_none, busy, set_volume, make_call, 'h5a, 30, 1, 0, 0);
		add_step(b_up, evt_none, busy, end_call_b, make_call, 'h5a, 30, 1, 443, 8);
		add_step(b_enter, evt_none, busy, end_call_b, stop_call, 'h5a, 30, 1, 443, 8);
		add_step(b_none, call_ended, idle, def_welcome, stop_call, 'h5a, 30, 1, 72, 7);
		// incoming, answer then reject from the menu
		add_step(b_none, incoming_call, incoming, def_incoming, stop_call, 'h5a, 30, 1, 361, 13);
		add_step(b_down, evt_none, incoming, accept, stop_call, 'h5a, 30, 1, 375, 20);
		add_step(b_right, evt_none, incoming, accept, accept_call, 'h5a, 30, 1, 375, 20);
		add_step(b_down, evt_none, incoming, reject, accept_call, 'h5a, 30, 1, 396, 20);
		add_step(b_enter, evt_none, incoming, reject, stop_call, 'h5a, 30, 1, 396, 20);
		add_step(b_none, call_ended, idle, def_welcome, stop_call, 'h5a, 30, 1, 72, 7);
		// unanswered with voicemail on, ring timer decides
		add_step(b_none, incoming_call, incoming, def_incoming, stop_call, 'h5a, 30, 1, 361, 13);
		add_step(b_up, evt_none, incoming, send_to_v, stop_call, 'h5a, 30, 1, 417, 17);
		add_step(b_down, evt_none, incoming, def_incoming, stop_call, 'h5a, 30, 1, 361, 13);
		set_repeat(1, ring_cycles + 16);
		add_step(b_none, evt_none, incoming, def_incoming, go_to_voicemail, 'h5a, 30, 1, -1, -1);
		add_step(b_none, sent_to_v, idle, def_welcome, go_to_voicemail, 'h5a, 30, 1, 72, 7);
	endfunction

	//////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d clock cycles", cycle_limit);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	initial begin
		reset = 1'b1;
		{up, down, left, right, enter} = 5'b00000;
		switches = '0;
		cf_present = 1'b0;
		app_event = evt_none;
		build_table();
		foreach (steps[i])
			press_total += steps[i].reps;
		cycle_limit = reset_cycles + 2 * press_total * 2 + 4 * ring_cycles;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		@(negedge clk); // first text load just out of reset
		check_value("text_start", 32'(text_start), 32'd1);
		foreach (steps[i]) begin
			step_idx = i;
			apply_step(steps[i]);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* compile.f */
+incdir+verilog
verilog/phone_ui_pkg.sv
verilog/call_control_fsm.sv
verilog/menu_text_rom.sv
verilog/ring_timer.sv
verilog/ui_config_regs.sv
verilog/phone_ui_top.sv
testbench/phone_ui_properties.sv
testbench/phone_ui_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the phone UI testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module phone_ui_tb -f compile.f -o Vphone_ui_tb
sim_out=$(./obj_dir/Vphone_ui_tb) || true
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -q "=== PASS ==="; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
